// File: all.f
ddr_mux_pkg.sv
hw/sync_fifo.sv
hw/port_arbiter.sv
hw/read_return_router.sv
hw/mux_ddr_access.sv
test/ddr_model.sv
test/tb_mux_ddr_access.sv

// File: Makefile
SRCS := ddr_mux_pkg.sv $(wildcard hw/*.sv) $(wildcard test/*.sv)

.PHONY: run clean

obj_dir/Vtb_mux_ddr_access: all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_mux_ddr_access

run: obj_dir/Vtb_mux_ddr_access
	out="$$(./obj_dir/Vtb_mux_ddr_access)"; echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

// File: test/tb_mux_ddr_access.sv
// testbench for the multi-port ddr access mux with a behavioral ddr controller
`timescale 1ns/100ps

module tb_mux_ddr_access;

	localparam int num_entries = 10;

	logic                   afi_phy_clk;
	logic                   rst;
	ddr_mux_pkg::ddr_addr_t wport_addr [2];
	ddr_mux_pkg::ddr_data_t wport_data [2];
	logic [1:0]             wport_req;
	logic [1:0]             wport_ready;
	ddr_mux_pkg::ddr_addr_t rport_addr [2];
	logic [1:0]             rport_req;
	logic [1:0]             rport_ready;
	ddr_mux_pkg::ddr_data_t rport_data [2];
	logic [1:0]             rport_data_valid;
	logic                   local_init_done;
	logic                   local_ready;
	ddr_mux_pkg::ddr_data_t local_rdata;
	logic                   local_rdata_valid;
	ddr_mux_pkg::ddr_cmd_t  local_cmd;
	logic [1:0]             ready_mode;
	logic                   acc_valid;
	ddr_mux_pkg::ddr_addr_t acc_addr;
	logic                   acc_write;

	// stimulus table with write flag, port, address, data or expected word and name
	logic                   t_write [num_entries];
	int                     t_port  [num_entries];
	ddr_mux_pkg::ddr_addr_t t_addr  [num_entries];
	ddr_mux_pkg::ddr_data_t t_data  [num_entries];
	string                  t_name  [num_entries];

	ddr_mux_pkg::ddr_addr_t acc_q [$];
	int                     exp_idx [2][$];
	int                     writes_issued;
	int                     writes_done;
	int                     errors;
	int                     base;

	mux_ddr_access mux_ddr_access_i (.*);

	ddr_model ddr_model_i (.*);

	initial
	begin
		afi_phy_clk = 1'b0;
		forever #50 afi_phy_clk = ~afi_phy_clk;
	end

	// memory contents the model starts with
	function automatic ddr_mux_pkg::ddr_data_t fill_word(input logic [7:0] a);
		fill_word = {a, ~a, a ^ 8'h5a, 8'hc3};
	endfunction

	task automatic set_entry(input int idx, input logic wr, input int port,
		input ddr_mux_pkg::ddr_addr_t addr, input ddr_mux_pkg::ddr_data_t data,
		input string name);
		t_write[idx] = wr;
		t_port[idx]  = port;
		t_addr[idx]  = addr;
		t_data[idx]  = data;
		t_name[idx]  = name;
	endtask

	task automatic issue_write(input int port, input ddr_mux_pkg::ddr_addr_t addr,
		input ddr_mux_pkg::ddr_data_t data);
		int i;
		i = port / 2;
		// ready only changes on a rising edge
		@(negedge afi_phy_clk);
		while (!wport_ready[i])
			@(negedge afi_phy_clk);
		@(posedge afi_phy_clk);
		wport_addr[i] <= addr;
		wport_data[i] <= data;
		wport_req[i]  <= 1'b1;
		@(posedge afi_phy_clk);
		wport_req[i]  <= 1'b0;
		writes_issued++;
	endtask

	task automatic issue_read(input int idx);
		int i;
		i = t_port[idx] / 2;
		@(negedge afi_phy_clk);
		while (!rport_ready[i])
			@(negedge afi_phy_clk);
		@(posedge afi_phy_clk);
		rport_addr[i] <= t_addr[idx];
		rport_req[i]  <= 1'b1;
		@(posedge afi_phy_clk);
		rport_req[i]  <= 1'b0;
		exp_idx[i].push_back(idx);
	endtask

	task automatic wait_idle();
		while (writes_done != writes_issued || exp_idx[0].size() != 0 ||
			exp_idx[1].size() != 0)
			@(negedge afi_phy_clk);
	endtask

	task automatic check_addr(input string name, input int pos,
		input ddr_mux_pkg::ddr_addr_t expected);
		if (acc_q[pos] !== expected)
		begin
			$display("FAIL %s expected %h actual %h", name, expected, acc_q[pos]);
			errors++;
		end
	endtask

	// accepted command order and write completion
	always @(posedge afi_phy_clk)
	begin
		if (acc_valid)
		begin
			acc_q.push_back(acc_addr);
			if (acc_write)
				writes_done <= writes_done + 1;
		end
	end

	// returned words are compared per read port in request order
	always @(posedge afi_phy_clk)
	begin
		for (int i = 0; i < 2; i++)
		begin
			if (!rst && rport_data_valid[i])
			begin
				if (exp_idx[i].size() == 0)
				begin
					$display("read port %0d returned a word nobody asked for", 2 * i + 1);
					errors++;
				end
				else if (rport_data[i] !== t_data[exp_idx[i][0]])
				begin
					$display("FAIL %s expected %h actual %h", t_name[exp_idx[i][0]],
						t_data[exp_idx[i][0]], rport_data[i]);
					errors++;
					void'(exp_idx[i].pop_front());
				end
				else
				begin
					void'(exp_idx[i].pop_front());
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// watchdog
	initial
	begin
		repeat (num_entries * 64) @(posedge afi_phy_clk);
		$display("timeout, the run did not finish in time");
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// main sequence
	initial
	begin
		rst           = 1'b1;
		wport_addr    = '{default: '0};
		wport_data    = '{default: '0};
		rport_addr    = '{default: '0};
		wport_req     = '0;
		rport_req     = '0;
		ready_mode    = 2'd0;
		writes_issued = 0;
		writes_done   = 0;
		errors        = 0;

		set_entry(0, 1'b1, 0, 32'd10, 32'hdeadbeef, "wr_p0_a10");
		set_entry(1, 1'b0, 1, 32'd10, 32'hdeadbeef, "rd_p1_a10");
		set_entry(2, 1'b1, 2, 32'd20, 32'h12345678, "wr_p2_a20");
		set_entry(3, 1'b0, 3, 32'd20, 32'h12345678, "rd_p3_a20");
		set_entry(4, 1'b0, 1, 32'd33, fill_word(8'd33), "rd_p1_a33");
		set_entry(5, 1'b0, 3, 32'd47, fill_word(8'd47), "rd_p3_a47");
		set_entry(6, 1'b0, 1, 32'd58, fill_word(8'd58), "rd_p1_a58");
		set_entry(7, 1'b0, 3, 32'd61, fill_word(8'd61), "rd_p3_a61");
		set_entry(8, 1'b1, 2, 32'd77, 32'ha5a50f0f, "wr_p2_a77");
		set_entry(9, 1'b0, 1, 32'd77, 32'ha5a50f0f, "rd_p1_a77");

		repeat (3) @(posedge afi_phy_clk);
		rst <= 1'b0;

		// nothing moves before the first request
		repeat (5)
		begin
			@(negedge afi_phy_clk);
			if (local_cmd.write_req !== 1'b0 || local_cmd.read_req !== 1'b0 ||
				rport_data_valid !== 2'b00)
			begin
				$display("FAIL reset expected 000 actual %b%b%b", local_cmd.write_req,
					local_cmd.read_req, |rport_data_valid);
				errors++;
			end
			// empty queues leave every port ready
			if (wport_ready !== 2'b11 || rport_ready !== 2'b11)
			begin
				$display("FAIL reset_ready expected 1111 actual %b%b", wport_ready,
					rport_ready);
				errors++;
			end
		end

		// a read waits for earlier writes to reach the controller
		for (int n = 0; n < num_entries; n++)
		begin
			if (t_write[n])
				issue_write(t_port[n], t_addr[n], t_data[n]);
			else
			begin
				while (writes_done != writes_issued)
					@(negedge afi_phy_clk);
				issue_read(n);
			end
		end
		wait_idle();

		// fair polling with both write ports loaded behind a held ready
		ready_mode <= 2'd1;
		repeat (3) @(posedge afi_phy_clk);
		ready_mode <= 2'd2;
		repeat (2) @(posedge afi_phy_clk);
		base = acc_q.size();
		for (int k = 0; k < 3; k++)
			issue_write(0, 32'd200 + k, 32'h1000 + k);
		for (int k = 0; k < 3; k++)
			issue_write(2, 32'd210 + k, 32'h2000 + k);
		ready_mode <= 2'd1;
		wait_idle();
		for (int k = 0; k < 3; k++)
		begin
			check_addr("fair_poll", base + 2 * k, 32'd200 + k);
			check_addr("fair_poll", base + 2 * k + 1, 32'd210 + k);
		end

		// ready level on port 0
		ready_mode <= 2'd2;
		repeat (2) @(posedge afi_phy_clk);
		base = acc_q.size();
		for (int k = 0; k < 4; k++)
			issue_write(0, 32'd100 + k, 32'h3000 + k);
		@(negedge afi_phy_clk);
		if (wport_ready[0] !== 1'b0)
		begin
			$display("FAIL ready_level expected 0 actual %b", wport_ready[0]);
			errors++;
		end
		fork
			issue_write(0, 32'd104, 32'h3004);
			begin
				repeat (3) @(posedge afi_phy_clk);
				ready_mode <= 2'd1;
			end
		join
		wait_idle();
		for (int k = 0; k < 5; k++)
			check_addr("ready_level", base + k, 32'd100 + k);

		repeat (4) @(posedge afi_phy_clk);
		$display("%0d errors", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: test/ddr_model.sv
// behavioral ddr controller with word memory, random ready and fixed read latency
`timescale 1ns/100ps

module ddr_model
(
	input  logic                   rst,
	input  logic                   afi_phy_clk,
	// mode 0 gives random ready, 1 holds it high and 2 holds it low
	input  logic [1:0]             ready_mode,
	input  ddr_mux_pkg::ddr_cmd_t  local_cmd,
	output logic                   local_init_done,
	output logic                   local_ready,
	output ddr_mux_pkg::ddr_data_t local_rdata,
	output logic                   local_rdata_valid,
	// one strobe per accepted command a cycle after acceptance
	output logic                   acc_valid,
	output ddr_mux_pkg::ddr_addr_t acc_addr,
	output logic                   acc_write
);

	localparam int read_latency = 4;

	ddr_mux_pkg::ddr_data_t mem [256];
	logic                   pipe_v [read_latency];
	ddr_mux_pkg::ddr_data_t pipe_d [read_latency];
	logic [31:0]            lfsr;
	logic                   take;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	initial
	begin
		for (int i = 0; i < 256; i++)
		begin
			mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
		end
	end

	assign take = local_ready && (local_cmd.write_req || local_cmd.read_req);
	assign local_rdata       = pipe_d[read_latency-1];
	assign local_rdata_valid = pipe_v[read_latency-1];

	always @(posedge afi_phy_clk)
	begin
		if (rst)
		begin
			local_init_done <= 1'b0;
			local_ready     <= 1'b0;
			lfsr            <= 32'h3b83;
			acc_valid       <= 1'b0;
			for (int i = 0; i < read_latency; i++)
			begin
				pipe_v[i] <= 1'b0;
			end
		end
		else
		begin
			local_init_done <= 1'b1;
			if (ready_mode == 2'd1)
				local_ready <= 1'b1;
			else if (ready_mode == 2'd2)
				local_ready <= 1'b0;
			else
			begin
				// one lfsr step per ready bit
				local_ready <= lfsr[0];
				lfsr        <= lfsr_next(lfsr);
			end
			if (take && local_cmd.write_req)
			begin
				mem[local_cmd.address[7:0]] <= local_cmd.wdata;
			end
			pipe_v[0] <= take && local_cmd.read_req;
			pipe_d[0] <= mem[local_cmd.address[7:0]];
			for (int i = 1; i < read_latency; i++)
			begin
				pipe_v[i] <= pipe_v[i-1];
				pipe_d[i] <= pipe_d[i-1];
			end
			acc_valid <= take;
			acc_addr  <= local_cmd.address;
			acc_write <= local_cmd.write_req;
		end
	end

endmodule

// File: hw/mux_ddr_access.sv
// multi-port ddr access mux with request queues, polling arbiter and read return routing
`timescale 1ns/100ps

module mux_ddr_access
(
	input  logic                   rst,
	input  logic                   afi_phy_clk,
	// write ports 0 and 2
	input  ddr_mux_pkg::ddr_addr_t wport_addr [ddr_mux_pkg::num_ports/2],
	input  ddr_mux_pkg::ddr_data_t wport_data [ddr_mux_pkg::num_ports/2],
	input  logic [ddr_mux_pkg::num_ports/2-1:0] wport_req,
	output logic [ddr_mux_pkg::num_ports/2-1:0] wport_ready,
	// read ports 1 and 3
	input  ddr_mux_pkg::ddr_addr_t rport_addr [ddr_mux_pkg::num_ports/2],
	input  logic [ddr_mux_pkg::num_ports/2-1:0] rport_req,
	output logic [ddr_mux_pkg::num_ports/2-1:0] rport_ready,
	output ddr_mux_pkg::ddr_data_t rport_data [ddr_mux_pkg::num_ports/2],
	output logic [ddr_mux_pkg::num_ports/2-1:0] rport_data_valid,
	// ddr controller side
	input  logic                   local_init_done,
	input  logic                   local_ready,
	input  ddr_mux_pkg::ddr_data_t local_rdata,
	input  logic                   local_rdata_valid,
	output ddr_mux_pkg::ddr_cmd_t  local_cmd
);

	ddr_mux_pkg::wr_cmd_t    wr_head [ddr_mux_pkg::num_ports/2];
	ddr_mux_pkg::ddr_addr_t  rd_head [ddr_mux_pkg::num_ports/2];
	logic [ddr_mux_pkg::req_fifo_log2:0] wr_usedw  [ddr_mux_pkg::num_ports/2];
	logic [ddr_mux_pkg::req_fifo_log2:0] rd_usedw  [ddr_mux_pkg::num_ports/2];
	logic [ddr_mux_pkg::ret_fifo_log2:0] ret_usedw [ddr_mux_pkg::num_ports/2];
	logic [ddr_mux_pkg::num_ports/2-1:0] wr_empty;
	logic [ddr_mux_pkg::num_ports/2-1:0] rd_empty;
	ddr_mux_pkg::port_mask_t pending;
	ddr_mux_pkg::port_mask_t pop;
	logic                    tag_push;
	ddr_mux_pkg::port_num_t  tag_port;

	////////////////////////////////////////////////////////////
	// request queues, pair i holds write port 2*i and read port 2*i+1
	for (genvar i = 0; i < ddr_mux_pkg::num_ports / 2; i++)
	begin : g_req
		sync_fifo #(
			.width      ($bits(ddr_mux_pkg::wr_cmd_t)),
			.log2_depth (ddr_mux_pkg::req_fifo_log2)
		) wr_fifo_i (
			.rst         (rst),
			.afi_phy_clk (afi_phy_clk),
			.data        ({wport_addr[i], wport_data[i]}),
			.wrreq       (wport_req[i] && wport_ready[i]),
			.rdreq       (pop[2*i]),
			.q           (wr_head[i]),
			.empty       (wr_empty[i]),
			.usedw       (wr_usedw[i])
		);

		sync_fifo #(
			.width      (ddr_mux_pkg::addr_width),
			.log2_depth (ddr_mux_pkg::req_fifo_log2)
		) rd_fifo_i (
			.rst         (rst),
			.afi_phy_clk (afi_phy_clk),
			.data        (rport_addr[i]),
			.wrreq       (rport_req[i] && rport_ready[i]),
			.rdreq       (pop[2*i+1]),
			.q           (rd_head[i]),
			.empty       (rd_empty[i]),
			.usedw       (rd_usedw[i])
		);

		assign pending[2*i]   = !wr_empty[i];
		assign pending[2*i+1] = !rd_empty[i];

		// reads also wait for room in their return fifo
		assign wport_ready[i] = (wr_usedw[i] < ddr_mux_pkg::req_ready_limit);
		assign rport_ready[i] = (rd_usedw[i] < ddr_mux_pkg::req_ready_limit) &&
			(ret_usedw[i] < ddr_mux_pkg::ret_ready_limit);
	end

	////////////////////////////////////////////////////////////
	// arbitration and read return
	port_arbiter port_arbiter_i (
		.rst             (rst),
		.afi_phy_clk     (afi_phy_clk),
		.local_init_done (local_init_done),
		.local_ready     (local_ready),
		.wr_head         (wr_head),
		.rd_head         (rd_head),
		.pending         (pending),
		.pop             (pop),
		.tag_push        (tag_push),
		.tag_port        (tag_port),
		.local_cmd       (local_cmd)
	);

	read_return_router read_return_router_i (
		.rst               (rst),
		.afi_phy_clk       (afi_phy_clk),
		.tag_push          (tag_push),
		.tag_port          (tag_port),
		.local_rdata       (local_rdata),
		.local_rdata_valid (local_rdata_valid),
		.rport_data        (rport_data),
		.rport_data_valid  (rport_data_valid),
		.ret_usedw         (ret_usedw)
	);

endmodule

// File: hw/read_return_router.sv
// routes returned ddr read data to the read port that issued it
`timescale 1ns/100ps

module read_return_router
(
	input  logic                   rst,
	input  logic                   afi_phy_clk,
	input  logic                   tag_push,
	input  ddr_mux_pkg::port_num_t tag_port,
	input  ddr_mux_pkg::ddr_data_t local_rdata,
	input  logic                   local_rdata_valid,
	output ddr_mux_pkg::ddr_data_t rport_data [ddr_mux_pkg::num_ports/2],
	output logic [ddr_mux_pkg::num_ports/2-1:0] rport_data_valid,
	output logic [ddr_mux_pkg::ret_fifo_log2:0] ret_usedw [ddr_mux_pkg::num_ports/2]
);

	ddr_mux_pkg::port_num_t tag_q;
	logic                   tag_empty;

	// one tag per issued read, in issue order
	sync_fifo #(
		.width      ($bits(ddr_mux_pkg::port_num_t)),
		.log2_depth (ddr_mux_pkg::ret_fifo_log2)
	) tag_fifo_i (
		.rst         (rst),
		.afi_phy_clk (afi_phy_clk),
		.data        (tag_port),
		.wrreq       (tag_push),
		.rdreq       (local_rdata_valid),
		.q           (tag_q),
		.empty       (tag_empty),
		.usedw       ()
	);

	////////////////////////////////////////////////////////////
	// return fifos, index i serves read port 2*i+1
	for (genvar i = 0; i < ddr_mux_pkg::num_ports / 2; i++)
	begin : g_ret
		logic ret_empty;
		logic ret_wr;

		assign ret_wr = local_rdata_valid && (tag_q == ddr_mux_pkg::port_num_t'(2 * i + 1));

		// drains itself, one word per cycle
		sync_fifo #(
			.width      (ddr_mux_pkg::data_width),
			.log2_depth (ddr_mux_pkg::ret_fifo_log2)
		) ret_fifo_i (
			.rst         (rst),
			.afi_phy_clk (afi_phy_clk),
			.data        (local_rdata),
			.wrreq       (ret_wr),
			.rdreq       (!ret_empty),
			.q           (rport_data[i]),
			.empty       (ret_empty),
			.usedw       (ret_usedw[i])
		);

		assign rport_data_valid[i] = !ret_empty;
	end

	// every returned word must match a read the arbiter issued
	a_tag_present: assert property (@(posedge afi_phy_clk) disable iff (rst)
		local_rdata_valid |-> !tag_empty)
		else $error("local_rdata_valid with no outstanding read");

endmodule

// File: hw/port_arbiter.sv
// polling arbiter that picks a user port and drives the ddr command bus
`timescale 1ns/100ps

module port_arbiter
(
	input  logic                   rst,
	input  logic                   afi_phy_clk,
	input  logic                   local_init_done,
	input  logic                   local_ready,
	input  ddr_mux_pkg::wr_cmd_t   wr_head [ddr_mux_pkg::num_ports/2],
	input  ddr_mux_pkg::ddr_addr_t rd_head [ddr_mux_pkg::num_ports/2],
	input  ddr_mux_pkg::port_mask_t pending,
	output ddr_mux_pkg::port_mask_t pop,
	output logic                   tag_push,
	output ddr_mux_pkg::port_num_t tag_port,
	output ddr_mux_pkg::ddr_cmd_t  local_cmd
);

	ddr_mux_pkg::arb_state_t  state;
	ddr_mux_pkg::arb_state_t  next_state;
	ddr_mux_pkg::port_mask_t  last_mask;
	ddr_mux_pkg::port_mask_t  avail;
	ddr_mux_pkg::port_num_t   pick;
	ddr_mux_pkg::ddr_cmd_t    next_cmd;
	logic                     pick_valid;
	logic                     advance;

	////////////////////////////////////////////////////////////
	// port selection
	always_comb
	begin
		last_mask = '0;
		case (state)
			ddr_mux_pkg::serve_0: last_mask[0] = 1'b1;
			ddr_mux_pkg::serve_1: last_mask[1] = 1'b1;
			ddr_mux_pkg::serve_2: last_mask[2] = 1'b1;
			ddr_mux_pkg::serve_3: last_mask[3] = 1'b1;
			default:              last_mask = '0;
		endcase
	end

	assign avail = pending & ~last_mask;

	// lowest pending port wins, so scan from the top down
	always_comb
	begin
		pick = '0;
		for (int i = ddr_mux_pkg::num_ports - 1; i >= 0; i--)
		begin
			if (avail[i])
			begin
				pick = ddr_mux_pkg::port_num_t'(i);
			end
		end
	end

	assign pick_valid = local_ready && (|avail);

	// a held command only moves on once the controller takes it
	assign advance = (state == ddr_mux_pkg::idle) || local_ready;

	always_comb
	begin
		case (pick)
			2'd0:    next_state = ddr_mux_pkg::serve_0;
			2'd1:    next_state = ddr_mux_pkg::serve_1;
			2'd2:    next_state = ddr_mux_pkg::serve_2;
			default: next_state = ddr_mux_pkg::serve_3;
		endcase
	end

	// odd ports are reads and pick[1] selects the pair
	always_comb
	begin
		if (pick[0])
		begin
			next_cmd.address   = rd_head[pick[1]];
			next_cmd.wdata     = '0;
			next_cmd.write_req = 1'b0;
			next_cmd.read_req  = 1'b1;
		end
		else
		begin
			next_cmd.address   = wr_head[pick[1]].addr;
			next_cmd.wdata     = wr_head[pick[1]].data;
			next_cmd.write_req = 1'b1;
			next_cmd.read_req  = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// command register and pop strobes
	always_ff @(posedge afi_phy_clk)
	begin
		if (rst || !local_init_done)
		begin
			state               <= ddr_mux_pkg::idle;
			pop                 <= '0;
			tag_push            <= 1'b0;
			local_cmd.write_req <= 1'b0;
			local_cmd.read_req  <= 1'b0;
		end
		else
		begin
			// strobes last one cycle
			pop      <= '0;
			tag_push <= 1'b0;
			if (advance && pick_valid)
			begin
				state     <= next_state;
				local_cmd <= next_cmd;
				pop[pick] <= 1'b1;
				tag_push  <= pick[0];
				tag_port  <= pick;
			end
			else if (advance)
			begin
				state               <= ddr_mux_pkg::idle;
				local_cmd.write_req <= 1'b0;
				local_cmd.read_req  <= 1'b0;
			end
		end
	end

	// a command held by a low local_ready stays put and pops nothing
	a_cmd_held: assert property (@(posedge afi_phy_clk) disable iff (rst)
		(local_init_done && !local_ready && (local_cmd.write_req || local_cmd.read_req))
		|=> ($stable(local_cmd) && (pop == '0)))
		else $error("command changed or fifo popped while local_ready was low");

endmodule

// File: hw/sync_fifo.sv
// show-ahead synchronous fifo with occupancy count
`timescale 1ns/100ps

module sync_fifo #(
	parameter int width      = 32,
	parameter int log2_depth = 4
)
(
	input  logic                  rst,
	input  logic                  afi_phy_clk,
	input  logic [width-1:0]      data,
	input  logic                  wrreq,
	input  logic                  rdreq,
	output logic [width-1:0]      q,
	output logic                  empty,
	output logic [log2_depth:0]   usedw
);

	logic [width-1:0]      mem [2**log2_depth];
	logic [log2_depth-1:0] wr_ptr;
	logic [log2_depth-1:0] rd_ptr;
	logic                  full;

	// count reaches 2**log2_depth only when full
	assign full  = usedw[log2_depth];
	assign empty = (usedw == '0);

	// head entry is visible without a read strobe
	assign q = mem[rd_ptr];

	always_ff @(posedge afi_phy_clk)
	begin
		if (wrreq)
		begin
			mem[wr_ptr] <= data;
		end
	end

	////////////////////////////////////////////////////////////
	// pointers and occupancy
	always_ff @(posedge afi_phy_clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			usedw  <= '0;
		end
		else
		begin
			if (wrreq)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rdreq)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wrreq, rdreq})
				2'b10:   usedw <= usedw + 1'b1;
				2'b01:   usedw <= usedw - 1'b1;
				default: usedw <= usedw;
			endcase
		end
	end

	// upstream ready logic must keep these from happening
	a_no_overflow: assert property (@(posedge afi_phy_clk) disable iff (rst)
		wrreq |-> !full)
		else $error("sync_fifo write while full");

	a_no_underflow: assert property (@(posedge afi_phy_clk) disable iff (rst)
		rdreq |-> !empty)
		else $error("sync_fifo read while empty");

endmodule

// File: ddr_mux_pkg.sv
// shared widths, command structs and arbiter states for the multi-port ddr access mux
package ddr_mux_pkg;

	////////////////////////////////////////////////////////////
	// widths and depths
	localparam int addr_width      = 32;
	localparam int data_width      = 32;
	localparam int num_ports       = 4;
	localparam int req_fifo_log2   = 4;
	localparam int ret_fifo_log2   = 6;

	// ready drops once a fifo holds this many entries
	localparam int req_ready_limit = 4;
	localparam int ret_ready_limit = 32;

	////////////////////////////////////////////////////////////
	// types
	typedef logic [addr_width-1:0] ddr_addr_t;
	typedef logic [data_width-1:0] ddr_data_t;
	// even ports write, odd ports read
	typedef logic [1:0]            port_num_t;
	typedef logic [num_ports-1:0]  port_mask_t;

	// queued write, addr sits in the upper half
	typedef struct packed {
		ddr_addr_t addr;
		ddr_data_t data;
	} wr_cmd_t;

	// single-beat command to the ddr controller
	typedef struct packed {
		ddr_addr_t address;
		ddr_data_t wdata;
		logic      write_req;
		logic      read_req;
	} ddr_cmd_t;

	// serve_n also remembers port n as last served
	typedef enum logic [2:0] {
		idle,
		serve_0,
		serve_1,
		serve_2,
		serve_3
	} arb_state_t;

endpackage
